// ==== src/key_codes_pkg.sv ====
package key_codes_pkg;

	// ====================
	// Key word layout
	// ====================
	localparam int KEY_TOGGLE_BIT  = 10; // Flips once per new event
	localparam int KEY_PRESSED_BIT = 9;  // Make 1, break 0
	localparam int KEY_CODE_W      = 8;
	localparam int KEY_W           = KEY_TOGGLE_BIT + 1;

	// ====================
	// Scan codes
	// ====================

	// Cursor block
	localparam logic [KEY_CODE_W-1:0] KC_UP    = 8'h75;
	localparam logic [KEY_CODE_W-1:0] KC_DOWN  = 8'h72;
	localparam logic [KEY_CODE_W-1:0] KC_LEFT  = 8'h6B;
	localparam logic [KEY_CODE_W-1:0] KC_RIGHT = 8'h74;

	// Coin and start keys
	localparam logic [KEY_CODE_W-1:0] KC_ESC   = 8'h76;
	localparam logic [KEY_CODE_W-1:0] KC_F1    = 8'h05;
	localparam logic [KEY_CODE_W-1:0] KC_F2    = 8'h06;

	// Fire keys
	localparam logic [KEY_CODE_W-1:0] KC_SPACE = 8'h29;
	localparam logic [KEY_CODE_W-1:0] KC_CTRL  = 8'h14;
	localparam logic [KEY_CODE_W-1:0] KC_ALT   = 8'h11;

endpackage

// ==== src/cabinet_pkg.sv ====
package cabinet_pkg;

	// ====================
	// Player inputs
	// ====================
	localparam int PIN_W        = 10;
	localparam int PIN_FIRE1    = 0;
	localparam int PIN_FIRE2    = 1;
	localparam int PIN_START1   = 2;
	localparam int PIN_START2   = 3;
	localparam int PIN_SLAM     = 4; // Tilt switch
	localparam int PIN_COCKTAIL = 5;
	localparam int PIN_TEST     = 6;
	localparam int PIN_LCOIN    = 7;
	localparam int PIN_CCOIN    = 8;
	localparam int PIN_RCOIN    = 9;

	// Joystick word from the I/O controller
	localparam int JOY_W     = 8;
	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;

	// ====================
	// Status and reset
	// ====================
	localparam int STATUS_W      = 32;
	localparam int ST_RESET      = 0;
	localparam int ST_TEST       = 1;
	localparam int ST_ROTATE     = 2;
	localparam int ST_MENU_RESET = 7; // Reset entry in the OSD menu

	localparam int BTN_W     = 2;
	localparam int BTN_RESET = 1;

	localparam int CORE_RESET_HOLD  = 16;
	localparam int CORE_RESET_CNT_W = $clog2(CORE_RESET_HOLD) + 1;

	// Audio path
	localparam int AUDIO_W = 4;
	localparam int DAC_W   = 16;

endpackage

// ==== src/ctrl_buttons_if.sv ====
`timescale 1ns/1ps

interface ctrl_buttons_if;

	// Held states, high while the key is down
	logic up;
	logic down;
	logic left;
	logic right;
	logic coin;
	logic start1;
	logic start2;
	logic fire1;

	// Keyboard decoder side
	modport source (
		output up, down, left, right,
		output coin, start1, start2, fire1
	);

	// Control mapper side
	modport sink (
		input up, down, left, right,
		input coin, start1, start2, fire1
	);

endinterface

// ==== src/ps2_button_decoder.sv ====
`timescale 1ns/1ps

module ps2_button_decoder
	import key_codes_pkg::*;
(
	input  logic             clk_24,
	input  logic             rst_i,
	input  logic [KEY_W-1:0] ps2_key_i,
	ctrl_buttons_if.source   btn
);

	logic [KEY_W-1:0]      key_q;
	logic                  toggle_q;
	logic                  key_event;
	logic                  pressed;
	logic [KEY_CODE_W-1:0] code;

	// ====================
	// Event detect
	// ====================

	// Sampled key word and the toggle bit seen one cycle earlier
	always_ff @(posedge clk_24) begin
		key_q    <= ps2_key_i;
		toggle_q <= key_q[KEY_TOGGLE_BIT];
	end

	assign key_event = key_q[KEY_TOGGLE_BIT] != toggle_q; // New word from the controller
	assign pressed   = key_q[KEY_PRESSED_BIT];
	assign code      = key_q[KEY_CODE_W-1:0];

	// ====================
	// Held buttons
	// ====================
	always_ff @(posedge clk_24) begin
		if (rst_i) begin
			btn.up     <= 1'b0;
			btn.down   <= 1'b0;
			btn.left   <= 1'b0;
			btn.right  <= 1'b0;
			btn.coin   <= 1'b0;
			btn.start1 <= 1'b0;
			btn.start2 <= 1'b0;
			btn.fire1  <= 1'b0;
		end else if (key_event) begin
			case (code)
				KC_UP:    btn.up     <= pressed;
				KC_DOWN:  btn.down   <= pressed;
				KC_LEFT:  btn.left   <= pressed;
				KC_RIGHT: btn.right  <= pressed;
				KC_ESC:   btn.coin   <= pressed; // Centre coin slot
				KC_F1:    btn.start1 <= pressed;
				KC_F2:    btn.start2 <= pressed;
				KC_SPACE: btn.fire1  <= pressed;
				default: ; // Ctrl, alt and other keys leave every state alone
			endcase
		end
	end

endmodule

// ==== src/control_mapper.sv ====
`timescale 1ns/1ps

module control_mapper
	import cabinet_pkg::*;
(
	input  logic                clk_24,
	input  logic                rst_i,
	ctrl_buttons_if.sink        btn,
	input  logic [JOY_W-1:0]    joystick_0_i,
	input  logic [JOY_W-1:0]    joystick_1_i,
	input  logic [STATUS_W-1:0] status_i,
	output logic [PIN_W-1:0]    player_input_o,
	output logic [JOY_W-1:0]    joystick_o
);

	logic [JOY_W-1:0] joy_any;
	logic             rotate;
	logic             go_up;
	logic             go_down;
	logic             go_left;
	logic             go_right;
	logic [PIN_W-1:0] pin_act;

	// Either player's stick drives the single cabinet control
	assign joy_any = joystick_0_i | joystick_1_i;
	assign rotate  = status_i[ST_ROTATE];

	// ====================
	// Direction mapping
	// ====================

	// Monitor is mounted sideways, so without rotate the axes turn a quarter
	always_comb begin
		if (rotate) begin
			go_up    = btn.up    | joy_any[JOY_UP];
			go_down  = btn.down  | joy_any[JOY_DOWN];
			go_left  = btn.left  | joy_any[JOY_LEFT];
			go_right = btn.right | joy_any[JOY_RIGHT];
		end else begin
			go_up    = btn.right | joy_any[JOY_RIGHT];
			go_down  = btn.left  | joy_any[JOY_LEFT];
			go_left  = btn.up    | joy_any[JOY_UP];
			go_right = btn.down  | joy_any[JOY_DOWN];
		end
	end

	// ====================
	// Player inputs
	// ====================

	// Built active high here, inverted at the register
	always_comb begin
		pin_act = '0; // Fire2, slam, cocktail, side coins unused
		pin_act[PIN_FIRE1]  = btn.fire1 | joy_any[JOY_FIRE];
		pin_act[PIN_START1] = btn.start1;
		pin_act[PIN_START2] = btn.start2;
		pin_act[PIN_TEST]   = status_i[ST_TEST];
		pin_act[PIN_CCOIN]  = btn.coin;
	end

	always_ff @(posedge clk_24) begin
		if (rst_i) begin
			player_input_o <= '1;
			joystick_o     <= '1;
		end else begin
			player_input_o <= ~pin_act;
			// Same stick on both nibbles
			joystick_o     <= ~{2{go_right, go_left, go_down, go_up}};
		end
	end

endmodule

// ==== src/core_reset_gen.sv ====
`timescale 1ns/1ps

module core_reset_gen
	import cabinet_pkg::*;
(
	input  logic                clk_24,
	input  logic                rst_i,
	input  logic [STATUS_W-1:0] status_i,
	input  logic [BTN_W-1:0]    buttons_i,
	output logic                core_reset_o
);

	logic                        reset_req;
	logic [CORE_RESET_CNT_W-1:0] hold_cnt;

	// Board reset, OSD reset bits and the reset button
	assign reset_req = rst_i
		| status_i[ST_RESET]
		| status_i[ST_MENU_RESET]
		| buttons_i[BTN_RESET];

	// ====================
	// Reset stretch
	// ====================

	// Loaded with one less than the hold since the output register adds a cycle
	always_ff @(posedge clk_24) begin
		if (reset_req) begin
			hold_cnt     <= CORE_RESET_CNT_W'(CORE_RESET_HOLD - 1);
			core_reset_o <= 1'b1;
		end else begin
			core_reset_o <= hold_cnt != '0;
			if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1; // Stops at zero
		end
	end

endmodule

// ==== src/audio_dac.sv ====
`timescale 1ns/1ps

module audio_dac
	import cabinet_pkg::*;
(
	input  logic               clk_24,
	input  logic               rst_i,
	input  logic [AUDIO_W-1:0] audio_i,
	output logic               dac_o
);

	logic [DAC_W-1:0] sample;
	logic [DAC_W-1:0] acc_q;
	logic [DAC_W:0]   sum;

	// ====================
	// Sample expansion
	// ====================

	// Low DAC_W bits of the doubled audio pattern
	assign sample = DAC_W'({2{audio_i, audio_i, 2'b00}});

	// ====================
	// Sigma-delta loop
	// ====================

	// Carry out of the accumulator is the bit stream
	assign sum = {1'b0, acc_q} + {1'b0, sample};

	always_ff @(posedge clk_24) begin
		if (rst_i) begin
			acc_q <= '0;
			dac_o <= 1'b0;
		end else begin
			acc_q <= sum[DAC_W-1:0];
			dac_o <= sum[DAC_W]; // High density tracks the sample value
		end
	end

endmodule

// ==== src/arcade_controls_top.sv ====
`timescale 1ns/1ps

module arcade_controls_top
	import key_codes_pkg::*;
	import cabinet_pkg::*;
(
	input  logic                clk_24,
	input  logic                rst_i,

	// From the board I/O controller
	input  logic [KEY_W-1:0]    ps2_key_i,
	input  logic [JOY_W-1:0]    joystick_0_i,
	input  logic [JOY_W-1:0]    joystick_1_i,
	input  logic [STATUS_W-1:0] status_i,
	input  logic [BTN_W-1:0]    buttons_i,

	// From the game core
	input  logic [AUDIO_W-1:0]  audio_i,

	// To the game core, active low
	output logic [PIN_W-1:0]    player_input_o,
	output logic [JOY_W-1:0]    joystick_o,
	output logic                core_reset_o,

	// To the audio pin
	output logic                dac_o
);

	// Held keyboard buttons
	ctrl_buttons_if btn_bus ();

	// ====================
	// Controls
	// ====================
	ps2_button_decoder u_decoder (
		.clk_24    (clk_24),
		.rst_i     (rst_i),
		.ps2_key_i (ps2_key_i),
		.btn       (btn_bus.source)
	);

	control_mapper u_mapper (
		.clk_24         (clk_24),
		.rst_i          (rst_i),
		.btn            (btn_bus.sink),
		.joystick_0_i   (joystick_0_i),
		.joystick_1_i   (joystick_1_i),
		.status_i       (status_i),
		.player_input_o (player_input_o),
		.joystick_o     (joystick_o)
	);

	// ====================
	// Reset and audio
	// ====================
	core_reset_gen u_reset (
		.clk_24       (clk_24),
		.rst_i        (rst_i),
		.status_i     (status_i),
		.buttons_i    (buttons_i),
		.core_reset_o (core_reset_o)
	);

	audio_dac u_dac (
		.clk_24  (clk_24),
		.rst_i   (rst_i),
		.audio_i (audio_i),
		.dac_o   (dac_o)
	);

endmodule

// ==== sim/arcade_controls_properties.sv ====
`timescale 1ns/1ps

module arcade_controls_properties
	import cabinet_pkg::*;
(
	input logic                clk_24,
	input logic                rst_i,
	input logic [STATUS_W-1:0] status_i,
	input logic [BTN_W-1:0]    buttons_i,
	input logic [PIN_W-1:0]    player_input_o,
	input logic [JOY_W-1:0]    joystick_o,
	input logic                core_reset_o,
	input logic                dac_o
);

	int unsigned assert_fails = 0; // Summed into the testbench result
	logic        reset_req;

	assign reset_req = rst_i | status_i[ST_RESET] | status_i[ST_MENU_RESET]
		| buttons_i[BTN_RESET];

	// Registered outputs reach their reset values one edge into reset
	reset_outputs: assert property (@(posedge clk_24)
		rst_i |=> !dac_o && &player_input_o && &joystick_o)
		else begin
			$error("outputs not at reset values while rst_i is high");
			assert_fails++;
		end

	// ====================
	// Core reset hold
	// ====================
	for (genvar d = 1; d <= CORE_RESET_HOLD; d++) begin : g_hold
		reset_hold: assert property (@(posedge clk_24) $past(reset_req, d) |-> core_reset_o)
			else begin
				$error("core reset low %0d cycles after a reset request", d);
				assert_fails++;
			end
	end

	// Fire2, slam, cocktail and side coins are tied inactive
	unused_pins: assert property (@(posedge clk_24) disable iff (rst_i)
		player_input_o[PIN_FIRE2] && player_input_o[PIN_SLAM]
		&& player_input_o[PIN_COCKTAIL] && player_input_o[PIN_LCOIN]
		&& player_input_o[PIN_RCOIN])
		else begin
			$error("unused player input driven low");
			assert_fails++;
		end

endmodule

bind arcade_controls_top arcade_controls_properties u_props (
	.clk_24         (clk_24),
	.rst_i          (rst_i),
	.status_i       (status_i),
	.buttons_i      (buttons_i),
	.player_input_o (player_input_o),
	.joystick_o     (joystick_o),
	.core_reset_o   (core_reset_o),
	.dac_o          (dac_o)
);

// ==== sim/tb_arcade_controls.sv ====
`timescale 1ns/1ps

module tb_arcade_controls
	import key_codes_pkg::*;
	import cabinet_pkg::*;
();

	localparam logic [31:0] SEED = 32'h8ab70269;
	localparam int RESET_CYCLES  = 16;
	localparam int KEY_EVENTS    = 48;
	localparam int JOY_VECTORS   = 64;
	localparam int AUDIO_RUNS    = 3;
	localparam int AUDIO_CYCLES  = 65536; // One full accumulator period

	// Upper bound of all tests together
	localparam int RUN_CYCLES = RESET_CYCLES + 4*CORE_RESET_HOLD + KEY_EVENTS*4
		+ JOY_VECTORS + 3*(CORE_RESET_HOLD + 12) + AUDIO_RUNS*AUDIO_CYCLES;
	localparam int WATCHDOG_CYCLES = RUN_CYCLES + RUN_CYCLES/8;

	logic                clk_24;
	logic                rst_i;
	logic [KEY_W-1:0]    ps2_key_i;
	logic [JOY_W-1:0]    joystick_0_i;
	logic [JOY_W-1:0]    joystick_1_i;
	logic [STATUS_W-1:0] status_i;
	logic [BTN_W-1:0]    buttons_i;
	logic [AUDIO_W-1:0]  audio_i;
	logic [PIN_W-1:0]    player_input_o;
	logic [JOY_W-1:0]    joystick_o;
	logic                core_reset_o;
	logic                dac_o;

	int   error_count = 0;
	int   check_count = 0;
	logic key_toggle;

	// Expected held keyboard buttons
	logic held_up, held_down, held_left, held_right;
	logic held_coin, held_start1, held_start2, held_fire1;

	arcade_controls_top u_dut (
		.clk_24         (clk_24),
		.rst_i          (rst_i),
		.ps2_key_i      (ps2_key_i),
		.joystick_0_i   (joystick_0_i),
		.joystick_1_i   (joystick_1_i),
		.status_i       (status_i),
		.buttons_i      (buttons_i),
		.audio_i        (audio_i),
		.player_input_o (player_input_o),
		.joystick_o     (joystick_o),
		.core_reset_o   (core_reset_o),
		.dac_o          (dac_o)
	);

	initial begin
		clk_24 = 1'b0;
		forever #4 clk_24 = ~clk_24;
	end

	// ====================
	// Expected values
	// ====================
	function automatic logic [PIN_W-1:0] expected_player();
		logic [JOY_W-1:0] sticks;
		logic [PIN_W-1:0] active;
		sticks = joystick_0_i | joystick_1_i;
		active = '0;
		active[PIN_FIRE1]  = held_fire1 | sticks[JOY_FIRE];
		active[PIN_START1] = held_start1;
		active[PIN_START2] = held_start2;
		active[PIN_CCOIN]  = held_coin;
		active[PIN_TEST]   = status_i[ST_TEST];
		return ~active;
	endfunction

	function automatic logic [JOY_W-1:0] expected_joystick();
		logic [JOY_W-1:0] s;
		logic up, down, left, right;
		s = joystick_0_i | joystick_1_i;
		if (status_i[ST_ROTATE]) begin
			up    = held_up | s[JOY_UP];
			down  = held_down | s[JOY_DOWN];
			left  = held_left | s[JOY_LEFT];
			right = held_right | s[JOY_RIGHT];
		end else begin
			up    = held_right | s[JOY_RIGHT]; // Quarter turn
			down  = held_left | s[JOY_LEFT];
			left  = held_up | s[JOY_UP];
			right = held_down | s[JOY_DOWN];
		end
		return ~{right, left, down, up, right, left, down, up};
	endfunction

	// Audio value at bits 12, 6 and 2 of the 16-bit sample
	function automatic int expected_density(logic [AUDIO_W-1:0] a);
		return (int'(a) << 12) + (int'(a) << 6) + (int'(a) << 2);
	endfunction

	// ====================
	// Helpers
	// ====================
	task automatic next_cycle();
		@(posedge clk_24);
		#1;
	endtask

	task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_controls(string what);
		check_value({what, ", player_input_o"}, player_input_o, expected_player());
		check_value({what, ", joystick_o"}, joystick_o, expected_joystick());
	endtask

	task automatic update_model(logic [KEY_CODE_W-1:0] code, logic pressed);
		case (code)
			KC_UP:    held_up     = pressed;
			KC_DOWN:  held_down   = pressed;
			KC_LEFT:  held_left   = pressed;
			KC_RIGHT: held_right  = pressed;
			KC_ESC:   held_coin   = pressed;
			KC_F1:    held_start1 = pressed;
			KC_F2:    held_start2 = pressed;
			KC_SPACE: held_fire1  = pressed;
			default: ; // Ctrl, alt and unknown codes never reach the core
		endcase
	endtask

	// New key word; old state after two edges, new state after three
	task automatic send_key(logic [KEY_CODE_W-1:0] code, logic pressed);
		key_toggle = ~key_toggle;
		ps2_key_i  = {key_toggle, pressed, 1'b0, code}; // Extended flag clear
		next_cycle();
		next_cycle();
		check_controls($sformatf("key %0h two edges in", code));
		next_cycle();
		update_model(code, pressed);
		check_controls($sformatf("key %0h three edges in", code));
	endtask

	task automatic wait_core_reset_release(string source);
		int edges;
		edges = 0;
		do begin
			next_cycle();
			edges++;
		end while (core_reset_o && edges < 4*CORE_RESET_HOLD);
		check_count++;
		if (core_reset_o) begin
			error_count++;
			$display("core reset requested by %s was never released", source);
		end else begin
			check_value({source, ", edges to core reset release"}, edges, CORE_RESET_HOLD);
		end
	endtask

	// ====================
	// Tests
	// ====================
	task automatic test_reset_defaults();
		repeat (RESET_CYCLES) @(posedge clk_24);
		#1;
		rst_i = 1'b0;
		check_value("player_input_o after reset", player_input_o, {PIN_W{1'b1}});
		check_value("joystick_o after reset", joystick_o, {JOY_W{1'b1}});
		check_value("dac_o after reset", dac_o, 1'b0);
		check_value("core_reset_o after reset", core_reset_o, 1'b1);
		wait_core_reset_release("rst_i");
	endtask

	task automatic test_key_events();
		logic [KEY_CODE_W-1:0] keys [10] = '{KC_ESC, KC_F1, KC_F2, KC_SPACE, KC_CTRL,
			KC_ALT, KC_UP, KC_DOWN, KC_LEFT, KC_RIGHT};
		for (int rot = 0; rot < 2; rot++) begin
			status_i[ST_ROTATE] = rot[0];
			foreach (keys[i]) begin
				send_key(keys[i], 1'b1);
				send_key(keys[i], 1'b0);
			end
		end
		send_key(KC_SPACE, 1'b1);
		ps2_key_i[KEY_PRESSED_BIT] = 1'b0; // Toggle unchanged, so not an event
		repeat (4) next_cycle();
		check_controls("pressed bit without toggle");
		send_key(8'h1C, 1'b1); // Not a cabinet key
		send_key(KC_SPACE, 1'b0);
	endtask

	task automatic test_joysticks();
		send_key(KC_UP, 1'b1); // Held key ORed with the sticks
		for (int i = 0; i < JOY_VECTORS; i++) begin
			joystick_0_i        = JOY_W'($urandom);
			joystick_1_i        = JOY_W'($urandom);
			status_i[ST_ROTATE] = i[0];
			next_cycle();
			check_controls($sformatf("joystick vector %0d", i));
		end
		joystick_0_i = '0;
		joystick_1_i = '0;
		send_key(KC_UP, 1'b0);
	endtask

	task automatic test_switch();
		status_i[ST_TEST] = 1'b1;
		next_cycle();
		check_value("test bit with switch on", player_input_o[PIN_TEST], 1'b0);
		check_controls("test switch on");
		status_i[ST_TEST] = 1'b0;
		next_cycle();
		check_controls("test switch off");
	endtask

	task automatic test_core_reset();
		string names [3] = '{"status bit 0", "status bit 7", "buttons bit 1"};
		for (int s = 0; s < 3; s++) begin
			check_value({names[s], ", core reset idle"}, core_reset_o, 1'b0);
			case (s)
				0: status_i[ST_RESET] = 1'b1;
				1: status_i[ST_MENU_RESET] = 1'b1;
				default: buttons_i[BTN_RESET] = 1'b1;
			endcase
			next_cycle();
			check_value({names[s], ", core reset raised"}, core_reset_o, 1'b1);
			repeat (5) next_cycle();
			status_i[ST_RESET]      = 1'b0;
			status_i[ST_MENU_RESET] = 1'b0;
			buttons_i[BTN_RESET]    = 1'b0;
			wait_core_reset_release(names[s]);
		end
	endtask

	task automatic test_audio();
		logic [AUDIO_W-1:0] levels [AUDIO_RUNS] = '{4'h3, 4'h9, 4'hF};
		int highs;
		foreach (levels[i]) begin
			audio_i = levels[i];
			highs   = 0;
			repeat (AUDIO_CYCLES) begin
				next_cycle();
				if (dac_o)
					highs++;
			end
			check_value($sformatf("dac_o density for audio %0h", levels[i]), highs,
				expected_density(levels[i]));
		end
	endtask

	// ====================
	// Sequence
	// ====================
	initial begin
		void'($urandom(SEED));
		rst_i        = 1'b1;
		ps2_key_i    = '0;
		joystick_0_i = '0;
		joystick_1_i = '0;
		status_i     = '0;
		buttons_i    = '0;
		audio_i      = '0;
		key_toggle   = 1'b0;
		{held_up, held_down, held_left, held_right,
			held_coin, held_start1, held_start2, held_fire1} = '0;

		test_reset_defaults();
		test_key_events();
		test_joysticks();
		test_switch();
		test_core_reset();
		test_audio();

		$display("checks %0d, errors %0d, assertion failures %0d",
			check_count, error_count, u_dut.u_props.assert_fails);
		if (error_count == 0 && u_dut.u_props.assert_fails == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_24);
		$display("watchdog expired, the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

// ==== sim.f ====
src/key_codes_pkg.sv
src/cabinet_pkg.sv
src/ctrl_buttons_if.sv
src/ps2_button_decoder.sv
src/control_mapper.sv
src/core_reset_gen.sv
src/audio_dac.sv
src/arcade_controls_top.sv
sim/arcade_controls_properties.sv
sim/tb_arcade_controls.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and search the log for the pass line

cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir build.log "$LOG"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module tb_arcade_controls \
	-o tb_arcade_controls > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/tb_arcade_controls +verilator+error+limit+1000 > "$LOG" 2>&1 \
	|| echo "Simulator returned an error status"

grep -qx "Everything OK" "$LOG" \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL, see $LOG"; exit 1; }
